//--- hw/result_pkg.sv
package result_pkg;

	// Record field widths
	localparam int COORD_W          = 12;  // x or y origin, also the FIFO word width
	localparam int NUM_RESIZE       = 5;   // One mask bit per resize scale

	// Serialization
	localparam int WORDS_PER_RECORD = 3;   // x, y, candidate

	// FIFO geometry
	localparam int FIFO_DEPTH       = 24;  // Eight full records
	localparam int FIFO_AW          = 5;   // Addresses 0..23
	localparam int FIFO_CW          = 6;   // Count must reach 24

	// Word slot order inside a record
	localparam logic [1:0] SLOT_X    = 2'd0;
	localparam logic [1:0] SLOT_Y    = 2'd1;
	localparam logic [1:0] SLOT_CAND = 2'd2;

	// Candidate view of a FIFO word
	// Mask sits in the low bits, the rest stays zero
	typedef struct packed
	{
		logic [COORD_W-NUM_RESIZE-1:0] rsvd;  // Always written as zero
		logic [NUM_RESIZE-1:0]         mask;  // Matched resize scales
	} cand_view_t;

	// One FIFO word, decoded by slot
	typedef union packed
	{
		logic [COORD_W-1:0] coord;  // SLOT_X or SLOT_Y
		cand_view_t         cand;   // SLOT_CAND
	} result_word_u;

endpackage

//--- hw/result_packer.sv
`timescale 1ns/1ps

module result_packer
	import result_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_write_result,  // Record strobe
	input  logic [COORD_W-1:0]    i_x,
	input  logic [COORD_W-1:0]    i_y,
	input  logic [NUM_RESIZE-1:0] i_candidate,
	input  logic                  i_has_room,      // Three free words in the FIFO
	output logic                  o_wr_en,
	output result_word_u          o_wr_word,
	output logic                  o_write_busy,
	output logic                  o_overflow
);

	logic                  busy;      // Serializing a record
	logic [1:0]            slot;      // Word being written
	logic                  overflow;  // Drop pulse
	logic [COORD_W-1:0]    x_q;       // Holding registers
	logic [COORD_W-1:0]    y_q;
	logic [NUM_RESIZE-1:0] cand_q;
	logic                  accept;
	logic                  drop;

	// Decision made in the strobe cycle
	assign accept = i_write_result && !busy && i_has_room;
	assign drop   = i_write_result && !busy && !i_has_room;

	// Control state
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy     <= 1'b0;
			slot     <= SLOT_X;
			overflow <= 1'b0;
		end
		else
		begin
			overflow <= drop;  // One cycle only
			if (accept)
			begin
				busy <= 1'b1;
				slot <= SLOT_X;
			end
			else if (busy)
			begin
				if (slot == SLOT_CAND)  // Last word goes out this cycle
				begin
					busy <= 1'b0;
					slot <= SLOT_X;
				end
				else
					slot <= slot + 2'd1;
			end
		end
	end

	// Record capture on accept
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			x_q    <= i_x;
			y_q    <= i_y;
			cand_q <= i_candidate;
		end
	end

	// One union view per slot
	always_comb
	begin
		o_wr_word = '0;
		case (slot)
			SLOT_X:    o_wr_word.coord = x_q;
			SLOT_Y:    o_wr_word.coord = y_q;
			SLOT_CAND:
			begin
				o_wr_word.cand.rsvd = '0;  // Keep upper bits clean
				o_wr_word.cand.mask = cand_q;
			end
			default:   o_wr_word.coord = x_q;
		endcase
	end

	assign o_wr_en      = busy;  // Three write cycles per record
	assign o_write_busy = busy;
	assign o_overflow   = overflow;

endmodule

//--- hw/result_fifo.sv
`timescale 1ns/1ps

module result_fifo
	import result_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         i_wr_en,
	input  result_word_u i_wr_word,
	input  logic         i_rd_en,
	output result_word_u o_rd_word,     // Registered, one cycle after pop
	output logic         o_has_room,    // Room for a whole record
	output logic         o_has_record,  // At least one complete record
	output logic         o_empty
);

	result_word_u       mem [FIFO_DEPTH];  // Plain register storage
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_CW-1:0] count;             // Stored words
	result_word_u       rd_word;

	// Write port
	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			mem[wr_ptr] <= i_wr_word;
	end

	// Read data register
	always_ff @(posedge clk)
	begin
		if (i_rd_en)
			rd_word <= mem[rd_ptr];
	end

	// Pointers wrap at the depth, not at a power of two
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_wr_en)
			begin
				if (wr_ptr == FIFO_AW'(FIFO_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (i_rd_en)
			begin
				if (rd_ptr == FIFO_AW'(FIFO_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Word count
	always_ff @(posedge clk)
	begin
		if (reset)
			count <= '0;
		else
		begin
			case ({i_wr_en, i_rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Idle, or push and pop cancel
			endcase
		end
	end

	// Status from the count
	// A partial record never exceeds two words, so three means one complete
	assign o_has_room   = (count <= FIFO_CW'(FIFO_DEPTH - WORDS_PER_RECORD));
	assign o_has_record = (count >= FIFO_CW'(WORDS_PER_RECORD));
	assign o_empty      = !o_has_record;
	assign o_rd_word    = rd_word;

endmodule

//--- hw/result_unpacker.sv
`timescale 1ns/1ps

module result_unpacker
	import result_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_read_result,   // Record request strobe
	input  logic                  i_has_record,
	input  result_word_u          i_rd_word,       // Arrives one cycle after its pop
	output logic                  o_rd_en,
	output logic [COORD_W-1:0]    o_x,
	output logic [COORD_W-1:0]    o_y,
	output logic [NUM_RESIZE-1:0] o_candidate,
	output logic                  o_read_busy,
	output logic                  o_record_valid
);

	logic                  pop_busy;   // Issuing pops
	logic [1:0]            pop_cnt;    // Slot being popped
	logic                  cap_en;     // Word on i_rd_word is live
	logic [1:0]            cap_slot;   // Slot of that word
	logic                  read_busy;  // Strobe to valid pulse
	logic                  valid;
	logic                  start;
	logic                  last_cap;
	logic [COORD_W-1:0]    x_q;
	logic [COORD_W-1:0]    y_q;
	logic [NUM_RESIZE-1:0] cand_q;

	assign start    = i_read_result && !read_busy && i_has_record;
	assign last_cap = cap_en && (cap_slot == SLOT_CAND);

	// Pop counter
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pop_busy <= 1'b0;
			pop_cnt  <= SLOT_X;
		end
		else if (start)
		begin
			pop_busy <= 1'b1;
			pop_cnt  <= SLOT_X;
		end
		else if (pop_busy)
		begin
			if (pop_cnt == SLOT_CAND)
			begin
				pop_busy <= 1'b0;
				pop_cnt  <= SLOT_X;
			end
			else
				pop_cnt <= pop_cnt + 2'd1;
		end
	end

	// Capture counter trails the pops by one cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cap_en   <= 1'b0;
			cap_slot <= SLOT_X;
		end
		else
		begin
			cap_en   <= pop_busy;
			cap_slot <= pop_cnt;
		end
	end

	// Busy level and valid pulse
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			read_busy <= 1'b0;
			valid     <= 1'b0;
		end
		else
		begin
			valid <= last_cap;  // Fourth edge after the strobe
			if (start)
				read_busy <= 1'b1;
			else if (last_cap)
				read_busy <= 1'b0;
		end
	end

	// Field registers, held until the next record
	always_ff @(posedge clk)
	begin
		if (cap_en)
		begin
			case (cap_slot)
				SLOT_X:    x_q    <= i_rd_word.coord;
				SLOT_Y:    y_q    <= i_rd_word.coord;
				SLOT_CAND: cand_q <= i_rd_word.cand.mask;  // Reserved bits dropped
				default:   x_q    <= x_q;
			endcase
		end
	end

	assign o_rd_en        = pop_busy;
	assign o_x            = x_q;
	assign o_y            = y_q;
	assign o_candidate    = cand_q;
	assign o_read_busy    = read_busy;
	assign o_record_valid = valid;

endmodule

//--- hw/result_store_top.sv
`timescale 1ns/1ps

module result_store_top
	import result_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_write_result,
	input  logic [COORD_W-1:0]    i_x,
	input  logic [COORD_W-1:0]    i_y,
	input  logic [NUM_RESIZE-1:0] i_candidate,
	input  logic                  i_read_result,
	output logic                  o_write_busy,
	output logic                  o_overflow,
	output logic                  o_read_busy,
	output logic                  o_record_valid,
	output logic [COORD_W-1:0]    o_x,
	output logic [COORD_W-1:0]    o_y,
	output logic [NUM_RESIZE-1:0] o_candidate,
	output logic                  o_empty
);

	// Packer to FIFO
	logic         wr_en;
	result_word_u wr_word;
	logic         has_room;

	// FIFO to unpacker
	logic         rd_en;
	result_word_u rd_word;
	logic         has_record;

	// Input side, serializes x, y, mask
	result_packer result_packer_inst
	(
		.clk            (clk),
		.reset          (reset),
		.i_write_result (i_write_result),
		.i_x            (i_x),
		.i_y            (i_y),
		.i_candidate    (i_candidate),
		.i_has_room     (has_room),
		.o_wr_en        (wr_en),
		.o_wr_word      (wr_word),
		.o_write_busy   (o_write_busy),
		.o_overflow     (o_overflow)
	);

	// Word store
	result_fifo result_fifo_inst
	(
		.clk          (clk),
		.reset        (reset),
		.i_wr_en      (wr_en),
		.i_wr_word    (wr_word),
		.i_rd_en      (rd_en),
		.o_rd_word    (rd_word),
		.o_has_room   (has_room),
		.o_has_record (has_record),
		.o_empty      (o_empty)
	);

	// Output side, rebuilds the record
	result_unpacker result_unpacker_inst
	(
		.clk            (clk),
		.reset          (reset),
		.i_read_result  (i_read_result),
		.i_has_record   (has_record),
		.i_rd_word      (rd_word),
		.o_rd_en        (rd_en),
		.o_x            (o_x),
		.o_y            (o_y),
		.o_candidate    (o_candidate),
		.o_read_busy    (o_read_busy),
		.o_record_valid (o_record_valid)
	);

endmodule

//--- sim/result_store_sva.sv
`timescale 1ns/1ps

module result_store_sva
(
	input logic clk,
	input logic reset,
	input logic i_write_result,
	input logic i_read_result,
	input logic o_write_busy,
	input logic o_overflow,
	input logic o_read_busy,
	input logic o_record_valid
);

	// Valid closes a busy read
	valid_after_busy: assert property (@(posedge clk) disable iff (reset)
		o_record_valid |-> $past(o_read_busy))
		else $error("o_record_valid without o_read_busy the cycle before");

	overflow_not_busy: assert property (@(posedge clk) disable iff (reset)
		!(o_overflow && o_write_busy))
		else $error("o_overflow while o_write_busy is high");

	// Three words, three busy cycles
	write_busy_three: assert property (@(posedge clk) disable iff (reset)
		$rose(o_write_busy) |=> o_write_busy ##1 o_write_busy ##1 !o_write_busy)
		else $error("o_write_busy did not last three cycles");

	overflow_has_strobe: assert property (@(posedge clk) disable iff (reset)
		o_overflow |-> $past(i_write_result))
		else $error("o_overflow without a write strobe");

	valid_has_strobe: assert property (@(posedge clk) disable iff (reset)
		o_record_valid |-> $past(i_read_result, 5))
		else $error("o_record_valid without a read strobe");

endmodule

bind result_store_top result_store_sva result_store_sva_inst (.*);

//--- sim/result_store_checker.sv
`timescale 1ns/1ps

module result_store_checker
	import result_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_write_result,
	input  logic [COORD_W-1:0]    i_x,
	input  logic [COORD_W-1:0]    i_y,
	input  logic [NUM_RESIZE-1:0] i_candidate,
	input  logic                  i_read_result,
	input  logic                  i_write_busy,
	input  logic                  i_overflow,
	input  logic                  i_read_busy,
	input  logic                  i_record_valid,
	input  logic [COORD_W-1:0]    i_rec_x,
	input  logic [COORD_W-1:0]    i_rec_y,
	input  logic [NUM_RESIZE-1:0] i_rec_candidate,
	input  logic                  i_empty,
	output int                    o_error_count
);

	localparam int MAX_RECORDS = FIFO_DEPTH / WORDS_PER_RECORD;  // Eight
	localparam int REC_W       = 2 * COORD_W + NUM_RESIZE;

	logic [REC_W-1:0] model_q [$];  // Stored records with the oldest first
	logic [REC_W-1:0] expected;     // Record of the read in flight
	int               valid_timer;  // Edges left until the valid pulse
	logic             ovf_due;
	logic             valid_due;
	int               errors = 0;

	assign o_error_count = errors;

	task automatic compare_value(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		if (exp_val !== act_val)
		begin
			$display("[FAIL] %s expected %h actual %h", name, exp_val, act_val);
			errors++;
		end
	endtask

	always @(posedge clk)
	begin
		if (reset)
		begin
			model_q.delete();
			valid_timer = 0;
			ovf_due     = 1'b0;
		end
		else
		begin
			compare_value("o_overflow", 32'(ovf_due), 32'(i_overflow));
			ovf_due   = 1'b0;
			valid_due = 1'b0;
			if (valid_timer > 0)
			begin
				valid_timer--;
				valid_due = (valid_timer == 0);
			end
			compare_value("o_record_valid", 32'(valid_due), 32'(i_record_valid));
			if (valid_due && i_record_valid)
			begin
				compare_value("o_x", 32'(expected[REC_W-1 -: COORD_W]), 32'(i_rec_x));
				compare_value("o_y", 32'(expected[NUM_RESIZE +: COORD_W]), 32'(i_rec_y));
				compare_value("o_candidate", 32'(expected[NUM_RESIZE-1:0]),
					32'(i_rec_candidate));
			end
			// Empty level only when nothing is in flight
			if (!i_write_busy && !i_read_busy)
				compare_value("o_empty", 32'(model_q.size() == 0), 32'(i_empty));
			// Read seen before write in the same cycle
			if (i_read_result && !i_read_busy && model_q.size() > 0)
			begin
				expected    = model_q.pop_front();
				valid_timer = 5;  // Pulse sampled at the fifth edge after the strobe
			end
			if (i_write_result && !i_write_busy)
			begin
				if (model_q.size() < MAX_RECORDS)
					model_q.push_back({i_x, i_y, i_candidate});
				else
					ovf_due = 1'b1;  // Dropped and never enqueued
			end
		end
	end

endmodule

//--- sim/result_store_tb.sv
`timescale 1ns/1ps

module result_store_tb
	import result_pkg::*;
();

	localparam int MAX_LINES = 128;

	logic                  clk;
	logic                  reset;
	logic                  i_write_result;
	logic [COORD_W-1:0]    i_x;
	logic [COORD_W-1:0]    i_y;
	logic [NUM_RESIZE-1:0] i_candidate;
	logic                  i_read_result;
	logic                  o_write_busy;
	logic                  o_overflow;
	logic                  o_read_busy;
	logic                  o_record_valid;
	logic [COORD_W-1:0]    o_x;
	logic [COORD_W-1:0]    o_y;
	logic [NUM_RESIZE-1:0] o_candidate;
	logic                  o_empty;
	int                    error_count;  // From the checker

	// Parsed vector lines
	logic [7:0]  op_kind [MAX_LINES];
	logic [31:0] op_a    [MAX_LINES];
	logic [31:0] op_b    [MAX_LINES];
	logic [31:0] op_c    [MAX_LINES];
	int          num_lines;
	int          cycle_limit = 0;
	int          cycles      = 0;
	int          unknown_ops = 0;  // Lines with no known operation

	result_store_top result_store_top_inst (.*);

	result_store_checker result_store_checker_inst
	(
		.clk              (clk),
		.reset            (reset),
		.i_write_result   (i_write_result),
		.i_x              (i_x),
		.i_y              (i_y),
		.i_candidate      (i_candidate),
		.i_read_result    (i_read_result),
		.i_write_busy     (o_write_busy),
		.i_overflow       (o_overflow),
		.i_read_busy      (o_read_busy),
		.i_record_valid   (o_record_valid),
		.i_rec_x          (o_x),
		.i_rec_y          (o_y),
		.i_rec_candidate  (o_candidate),
		.i_empty          (o_empty),
		.o_error_count    (error_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // 100 ns period
	end

	// Watchdog with a limit set once the vectors are read
	always @(posedge clk)
	begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Errors: %0d", error_count + unknown_ops);
			$display("Some tests failed");
			$finish;
		end
	end

	// Pulls every operation out of the vector file
	task automatic load_vectors();
		int          fd;
		int          r;
		int          idle_total;
		logic [63:0] tok;
		string       rest;
		fd         = $fopen("sim/result_vectors.txt", "r");
		num_lines  = 0;
		idle_total = 0;
		if (fd == 0)
		begin
			$display("Could not open the vector file sim/result_vectors.txt");
			return;
		end
		while (!$feof(fd) && num_lines < MAX_LINES)
		begin
			r = $fscanf(fd, " %s", tok);
			if (r != 1)
				break;
			if (tok == "#")
				r = $fgets(rest, fd);  // Comment line
			else
			begin
				op_kind[num_lines] = tok[7:0];
				op_a[num_lines]    = 0;
				op_b[num_lines]    = 0;
				op_c[num_lines]    = 0;
				if (tok == "W" || tok == "B")
					r = $fscanf(fd, " %h %h %h", op_a[num_lines], op_b[num_lines],
						op_c[num_lines]);
				else if (tok == "I")
				begin
					r = $fscanf(fd, " %d", op_a[num_lines]);
					idle_total += op_a[num_lines];
				end
				num_lines++;
			end
		end
		$fclose(fd);
		// Eight cycles per line plus idle lines, worst random gaps and margin
		cycle_limit = 8 * num_lines + idle_total + 3 * num_lines + 100 + cycles;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// One strobe cycle and a wait for both sides to go quiet
	task automatic issue_op(input logic wr, input logic rd, input int idx);
		@(negedge clk);
		i_write_result = wr;
		i_read_result  = rd;
		if (wr)
		begin
			i_x         = op_a[idx][COORD_W-1:0];
			i_y         = op_b[idx][COORD_W-1:0];
			i_candidate = op_c[idx][NUM_RESIZE-1:0];
		end
		@(negedge clk);
		i_write_result = 1'b0;
		i_read_result  = 1'b0;
		while (o_write_busy || o_read_busy)
			@(negedge clk);
	endtask

	initial
	begin
		int i;
		void'($urandom(21));  // Seed once
		reset          = 1'b1;
		i_write_result = 1'b0;
		i_read_result  = 1'b0;
		i_x            = '0;
		i_y            = '0;
		i_candidate    = '0;
		load_vectors();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		idle_cycles(2);
		for (i = 0; i < num_lines; i++)
		begin
			case (op_kind[i])
				"W": issue_op(1'b1, 1'b0, i);
				"R": issue_op(1'b0, 1'b1, i);
				"B": issue_op(1'b1, 1'b1, i);  // Push and pop overlap
				"I": idle_cycles(op_a[i]);
				default:
				begin
					$display("Unknown vector operation on line %0d", i);
					unknown_ops++;
				end
			endcase
			idle_cycles($urandom_range(3, 0));
		end
		idle_cycles(10);
		$display("Errors: %0d", error_count + unknown_ops);
		if (error_count == 0 && unknown_ops == 0 && num_lines > 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- sim/result_vectors.txt
# W x y cand : write record, values in hex
# R : read one record ; B x y cand : write and read in the same cycle ; I n : idle n cycles
# Empty read right after reset
R
I 6
W 123 456 1f
W 0ab 0cd 00
W fff 001 04
R
R
R
R
I 6
# Fill eight records, the ninth is dropped
W 001 010 01
W 002 020 02
W 003 030 04
W 004 040 08
W 005 050 10
W 006 060 1f
W 007 070 00
W 008 080 15
W 009 090 0a
I 3
R
R
R
R
R
R
R
R
R
I 6
# Push and pop overlap
W 111 222 03
B 333 444 1c
W 555 666 11
B 777 888 06
R
R
R
I 6

//--- all.f
hw/result_pkg.sv
hw/result_packer.sv
hw/result_fifo.sv
hw/result_unpacker.sv
hw/result_store_top.sv
sim/result_store_sva.sv
sim/result_store_checker.sv
sim/result_store_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module result_store_tb \
		-f all.f -o result_store_sim \
	&& out=$(./obj_dir/result_store_sim) \
	&& echo "$out" \
	&& echo "$out" | grep -q "All tests passed" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
